// ==== hdl/mux_spi.sv ====
module mux_spi #(
  parameter int n_dev = 8
) (
  input  logic [n_dev-1:0] reg_spi_mux,   // which devices follow the mcu
  input  logic [n_dev-1:0] cs_polarity,   // 1 for active high strobe parts
  input  logic             cs2,           // pass-through select, active lo
  input  logic             clk,           // spi clock pin, not the system clock
  input  logic             mosi,
  input  logic             dout,          // hub's own shifter
  input  logic [n_dev-1:0] vec_miso,
  output logic [n_dev-1:0] vec_cs,
  output logic [n_dev-1:0] vec_clk,
  output logic [n_dev-1:0] vec_mosi,
  output logic             miso
);

  logic [n_dev-1:0] cs_active;

  //////////////////////////////
  // towards the devices

  assign cs_active = reg_spi_mux & {n_dev{~cs2}};   // selected and cs2 asserted

  // polarity flips the idle level, e.g. 4094 strobe idles low
  assign vec_cs = ~(cs_active ^ cs_polarity);

  assign vec_clk  = reg_spi_mux & {n_dev{clk}};    // mask only
  assign vec_mosi = reg_spi_mux & {n_dev{mosi}};

  //////////////////////////////
  // back to the mcu

  // cs2 high means the hub itself talks
  assign miso = cs2 ? dout : |(reg_spi_mux & vec_miso);

endmodule

// ==== hdl/spi_frame_ctrl.sv ====
module spi_frame_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      bit_valid,
  input  logic                      frame_start,
  input  logic                      frame_abort,
  input  spi_periph_pkg::bit_cnt_t  bit_cnt,
  input  spi_periph_pkg::reg_data_t rx_byte,
  output logic                      load,
  output spi_periph_pkg::reg_data_t tx_byte,
  output logic                      wb_cyc,
  output logic                      wb_stb,
  output logic                      wb_we,
  output spi_periph_pkg::reg_addr_t wb_adr,
  output spi_periph_pkg::reg_data_t wb_dat_w,
  input  spi_periph_pkg::reg_data_t wb_dat_r,
  input  logic                      wb_ack
);

  localparam spi_periph_pkg::bit_cnt_t cmd_last  = 4'd7;    // last bit of byte 0
  localparam spi_periph_pkg::bit_cnt_t data_last = 4'd15;   // last bit of the frame

  spi_periph_pkg::ctrl_state_t state;
  logic bus_act;    // cyc and stb move together
  logic cmd_end;
  logic data_end;

  assign cmd_end  = bit_valid && (bit_cnt == cmd_last);
  assign data_end = bit_valid && (bit_cnt == data_last);

  assign wb_cyc = bus_act;
  assign wb_stb = bus_act;

  //////////////////////////////
  // fsm

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= spi_periph_pkg::idle;
      bus_act <= 1'b0;
      wb_we   <= 1'b0;
      load    <= 1'b0;
    end else begin
      load <= 1'b0;    // one cycle pulse
      if (frame_abort) begin
        // cs went high, drop everything
        state   <= spi_periph_pkg::idle;
        bus_act <= 1'b0;
      end else begin
        case (state)
          spi_periph_pkg::idle,
          spi_periph_pkg::done: begin
            if (frame_start)
              state <= spi_periph_pkg::cmd;
          end
          spi_periph_pkg::cmd: begin
            if (cmd_end) begin
              wb_we <= rx_byte[7];            // write flag
              if (rx_byte[7]) begin
                state <= spi_periph_pkg::data;  // wait for the data byte
              end else begin
                bus_act <= 1'b1;             // fetch now, before bit 8
                state   <= spi_periph_pkg::rd_bus;
              end
            end
          end
          spi_periph_pkg::rd_bus: begin
            if (wb_ack) begin
              bus_act <= 1'b0;
              load    <= 1'b1;               // into the shifter
              state   <= spi_periph_pkg::data;
            end
          end
          spi_periph_pkg::data: begin
            if (data_end) begin
              if (wb_we) begin
                bus_act <= 1'b1;
                state   <= spi_periph_pkg::wr_bus;
              end else begin
                state <= spi_periph_pkg::done;
              end
            end
          end
          spi_periph_pkg::wr_bus: begin
            if (wb_ack) begin
              bus_act <= 1'b0;
              state   <= spi_periph_pkg::done;
            end
          end
          default: state <= spi_periph_pkg::idle;
        endcase
      end
    end
  end

  //////////////////////////////
  // bus payload

  always_ff @(posedge clk) begin
    if (state == spi_periph_pkg::cmd && cmd_end)
      wb_adr <= rx_byte[6:0];
    if (state == spi_periph_pkg::data && data_end)
      wb_dat_w <= rx_byte;          // full second byte
    if (state == spi_periph_pkg::rd_bus && wb_ack)
      tx_byte <= wb_dat_r;          // goes out on bits 8..15
  end

endmodule

// ==== hdl/spi_periph_pkg.sv ====
package spi_periph_pkg;

  //////////////////////////////
  // widths

  typedef logic [6:0] reg_addr_t;   // 7 bit register address from the cmd byte
  typedef logic [7:0] reg_data_t;   // one spi byte, one register
  typedef logic [3:0] bit_cnt_t;    // bit position in a 16 bit frame

  //////////////////////////////
  // register map

  localparam reg_addr_t addr_spi_mux     = 7'd0;   // device select mask
  localparam reg_addr_t addr_cs_polarity = 7'd1;   // per device cs polarity
  localparam reg_addr_t addr_scratch     = 7'd2;   // free rw byte
  localparam reg_addr_t addr_id          = 7'd3;   // read only

  localparam reg_data_t id_value = 8'hA5;   // identity readback

  // frame controller states
  typedef enum logic [2:0] {
    idle,     // no frame
    cmd,      // shifting in the command byte
    rd_bus,   // wishbone read in flight
    data,     // second byte on the wire
    wr_bus,   // wishbone write in flight
    done      // wait for cs to go high
  } ctrl_state_t;

endpackage

// ==== hdl/spi_periph_top.sv ====
module spi_periph_top #(
  parameter int n_dev = 8
) (
  input  logic             clk,
  input  logic             rst,
  // mcu side
  input  logic             spi_clk,
  input  logic             spi_cs,      // register frames
  input  logic             spi_cs2,     // pass-through
  input  logic             spi_mosi,
  output logic             spi_miso,
  // device side
  output logic [n_dev-1:0] vec_cs,
  output logic [n_dev-1:0] vec_clk,
  output logic [n_dev-1:0] vec_mosi,
  input  logic [n_dev-1:0] vec_miso
);

  // shifter <-> controller
  logic                      bit_valid;
  logic                      frame_start;
  logic                      frame_abort;
  spi_periph_pkg::bit_cnt_t  bit_cnt;
  spi_periph_pkg::reg_data_t rx_byte;
  logic                      load;
  spi_periph_pkg::reg_data_t tx_byte;
  logic                      dout;

  // internal wishbone
  logic                      wb_cyc;
  logic                      wb_stb;
  logic                      wb_we;
  spi_periph_pkg::reg_addr_t wb_adr;
  spi_periph_pkg::reg_data_t wb_dat_w;
  spi_periph_pkg::reg_data_t wb_dat_r;
  logic                      wb_ack;

  // register outputs to the router
  logic [n_dev-1:0] reg_spi_mux;
  logic [n_dev-1:0] cs_polarity;

  //////////////////////////////
  // spi frame side

  spi_shift i_shift (
    .clk         (clk),
    .rst         (rst),
    .spi_clk     (spi_clk),
    .spi_cs      (spi_cs),
    .spi_mosi    (spi_mosi),
    .load        (load),
    .tx_byte     (tx_byte),
    .bit_valid   (bit_valid),
    .frame_start (frame_start),
    .frame_abort (frame_abort),
    .bit_cnt     (bit_cnt),
    .rx_byte     (rx_byte),
    .dout        (dout)
  );

  spi_frame_ctrl i_ctrl (
    .clk         (clk),
    .rst         (rst),
    .bit_valid   (bit_valid),
    .frame_start (frame_start),
    .frame_abort (frame_abort),
    .bit_cnt     (bit_cnt),
    .rx_byte     (rx_byte),
    .load        (load),
    .tx_byte     (tx_byte),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack)
  );

  //////////////////////////////
  // registers and routing

  spi_reg_bank #(
    .n_dev (n_dev)
  ) i_regs (
    .clk         (clk),
    .rst         (rst),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .reg_spi_mux (reg_spi_mux),
    .cs_polarity (cs_polarity)
  );

  // raw pins, no sync on this path
  mux_spi #(
    .n_dev (n_dev)
  ) i_mux (
    .reg_spi_mux (reg_spi_mux),
    .cs_polarity (cs_polarity),
    .cs2         (spi_cs2),
    .clk         (spi_clk),
    .mosi        (spi_mosi),
    .dout        (dout),
    .vec_miso    (vec_miso),
    .vec_cs      (vec_cs),
    .vec_clk     (vec_clk),
    .vec_mosi    (vec_mosi),
    .miso        (spi_miso)
  );

endmodule

// ==== hdl/spi_reg_bank.sv ====
module spi_reg_bank #(
  parameter int n_dev = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  spi_periph_pkg::reg_addr_t wb_adr,
  input  spi_periph_pkg::reg_data_t wb_dat_w,
  output spi_periph_pkg::reg_data_t wb_dat_r,
  output logic                      wb_ack,
  output logic [n_dev-1:0]          reg_spi_mux,
  output logic [n_dev-1:0]          cs_polarity
);

  logic [n_dev-1:0]          mux_q;       // device select mask
  logic [n_dev-1:0]          pol_q;       // cs polarity per device
  spi_periph_pkg::reg_data_t scratch_q;
  spi_periph_pkg::reg_data_t rd_data;
  logic                      bus_hit;

  // new request, not the ack cycle itself
  assign bus_hit = wb_cyc & wb_stb & ~wb_ack;

  //////////////////////////////
  // read mux

  always_comb begin
    case (wb_adr)
      spi_periph_pkg::addr_spi_mux:     rd_data = spi_periph_pkg::reg_data_t'(mux_q);
      spi_periph_pkg::addr_cs_polarity: rd_data = spi_periph_pkg::reg_data_t'(pol_q);
      spi_periph_pkg::addr_scratch:     rd_data = scratch_q;
      spi_periph_pkg::addr_id:          rd_data = spi_periph_pkg::id_value;
      default:                          rd_data = '0;   // unmapped
    endcase
  end

  //////////////////////////////
  // ack and writes

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack    <= 1'b0;
      mux_q     <= '0;     // nothing selected, vec_cs all high
      pol_q     <= '0;
      scratch_q <= '0;
    end else begin
      wb_ack <= bus_hit;   // single cycle, always acks
      if (bus_hit && wb_we) begin
        case (wb_adr)
          spi_periph_pkg::addr_spi_mux:     mux_q     <= wb_dat_w[n_dev-1:0];
          spi_periph_pkg::addr_cs_polarity: pol_q     <= wb_dat_w[n_dev-1:0];
          spi_periph_pkg::addr_scratch:     scratch_q <= wb_dat_w;
          default: ;                      // id and unmapped ignore writes
        endcase
      end
    end
  end

  // read data lines up with ack
  always_ff @(posedge clk) begin
    if (bus_hit)
      wb_dat_r <= rd_data;
  end

  assign reg_spi_mux = mux_q;
  assign cs_polarity = pol_q;

endmodule

// ==== hdl/spi_shift.sv ====
module spi_shift (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      spi_clk,
  input  logic                      spi_cs,
  input  logic                      spi_mosi,
  input  logic                      load,
  input  spi_periph_pkg::reg_data_t tx_byte,
  output logic                      bit_valid,
  output logic                      frame_start,
  output logic                      frame_abort,
  output spi_periph_pkg::bit_cnt_t  bit_cnt,
  output spi_periph_pkg::reg_data_t rx_byte,
  output logic                      dout
);

  logic [1:0] sclk_sync;   // two flop synchronizers
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       sclk_d;      // delayed copies for edge detect
  logic       cs_d;
  logic       sclk_rise;
  logic       cs_fall;
  logic       cs_rise;
  spi_periph_pkg::reg_data_t tx_sr;

  //////////////////////////////
  // pin sync and edges

  always_ff @(posedge clk) begin
    if (rst) begin
      sclk_sync <= '0;
      cs_sync   <= '1;    // cs idles high
      mosi_sync <= '0;
      sclk_d    <= 1'b0;
      cs_d      <= 1'b1;
    end else begin
      sclk_sync <= {sclk_sync[0], spi_clk};
      cs_sync   <= {cs_sync[0], spi_cs};
      mosi_sync <= {mosi_sync[0], spi_mosi};
      sclk_d    <= sclk_sync[1];
      cs_d      <= cs_sync[1];
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_d & ~cs_sync[1];   // only inside a frame
  assign cs_fall   = cs_d & ~cs_sync[1];
  assign cs_rise   = ~cs_d & cs_sync[1];

  //////////////////////////////
  // counter, shift registers

  always_ff @(posedge clk) begin
    if (rst) begin
      bit_valid   <= 1'b0;
      frame_start <= 1'b0;
      frame_abort <= 1'b0;
      bit_cnt     <= '1;
      tx_sr       <= '0;
    end else begin
      bit_valid   <= sclk_rise;
      frame_start <= cs_fall;
      frame_abort <= cs_rise;
      if (cs_fall)
        bit_cnt <= '1;                   // first rise wraps to 0
      else if (sclk_rise)
        bit_cnt <= bit_cnt + 4'd1;
      // clear at both ends so miso idles low
      if (cs_fall | cs_rise)
        tx_sr <= '0;
      else if (load)
        tx_sr <= tx_byte;                // preload for the second byte
      else if (sclk_rise)
        tx_sr <= {tx_sr[6:0], 1'b0};     // msb first
    end
  end

  // mosi into the receive byte
  always_ff @(posedge clk) begin
    if (sclk_rise)
      rx_byte <= {rx_byte[6:0], mosi_sync[1]};
  end

  assign dout = tx_sr[7];   // master samples on the next rise

endmodule

// ==== sim/spi_periph_asserts.sv ====
module spi_periph_asserts #(
  parameter int n_dev = 8
) (
  input logic                      clk,
  input logic                      rst,
  input logic                      wb_stb,
  input logic                      wb_ack,
  input logic                      wb_we,
  input spi_periph_pkg::reg_addr_t wb_adr,
  input spi_periph_pkg::reg_data_t wb_dat_w,
  input logic [n_dev-1:0]          reg_spi_mux,
  input logic [n_dev-1:0]          vec_clk,
  input logic [n_dev-1:0]          vec_mosi
);

  int fail_cnt = 0;   // picked up by the testbench at the end

  logic [n_dev-1:0] mask_bus;   // mask as last written over the bus

  //////////////////////////////
  // internal wishbone

  ack_with_stb: assert property (@(posedge clk) disable iff (rst) wb_ack |-> wb_stb)
    else begin
      fail_cnt++;
      $error("wb_ack high without wb_stb");
    end

  // request held until the slave answers
  stb_hold: assert property (@(posedge clk) disable iff (rst) wb_stb && !wb_ack |=> wb_stb)
    else begin
      fail_cnt++;
      $error("wb_stb dropped before wb_ack");
    end

  //////////////////////////////
  // mux gating

  // write request seen, new value holds from the ack cycle on
  always_ff @(posedge clk) begin
    if (rst)
      mask_bus <= '0;
    else if (wb_stb && wb_we && !wb_ack && wb_adr == spi_periph_pkg::addr_spi_mux)
      mask_bus <= wb_dat_w[n_dev-1:0];
  end

  clk_gated: assert property (@(posedge clk) disable iff (rst) (vec_clk & ~mask_bus) == '0)
    else begin
      fail_cnt++;
      $error("vec_clk active on an unselected device");
    end

  mosi_gated: assert property (@(posedge clk) disable iff (rst) (vec_mosi & ~mask_bus) == '0)
    else begin
      fail_cnt++;
      $error("vec_mosi active on an unselected device");
    end

endmodule

// top level sees the bus, the mask and the device pins together
bind spi_periph_top spi_periph_asserts #(
  .n_dev (n_dev)
) i_asserts (
  .clk         (clk),
  .rst         (rst),
  .wb_stb      (wb_stb),
  .wb_ack      (wb_ack),
  .wb_we       (wb_we),
  .wb_adr      (wb_adr),
  .wb_dat_w    (wb_dat_w),
  .reg_spi_mux (reg_spi_mux),
  .vec_clk     (vec_clk),
  .vec_mosi    (vec_mosi)
);

// ==== sim/spi_periph_tb.sv ====
module spi_periph_tb;

  localparam int n_dev       = 8;
  localparam int half_per    = 8;        // spi half period in clk cycles
  localparam int cycle_limit = 150000;   // ~400 frames of ~276 cycles plus margin

  logic             clk;
  logic             rst;
  logic             spi_clk;
  logic             spi_cs;
  logic             spi_cs2;
  logic             spi_mosi;
  logic             spi_miso;
  logic [n_dev-1:0] vec_cs;
  logic [n_dev-1:0] vec_clk;
  logic [n_dev-1:0] vec_mosi;
  logic [n_dev-1:0] vec_miso;

  spi_periph_pkg::reg_data_t model [0:7];   // register contents, addr 0..7
  spi_periph_pkg::reg_addr_t addr;
  spi_periph_pkg::reg_data_t data;
  spi_periph_pkg::reg_data_t dummy;
  int errors;
  int cycles;
  int cut;

  spi_periph_top #(
    .n_dev (n_dev)
  ) i_dut (
    .clk      (clk),
    .rst      (rst),
    .spi_clk  (spi_clk),
    .spi_cs   (spi_cs),
    .spi_cs2  (spi_cs2),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .vec_cs   (vec_cs),
    .vec_clk  (vec_clk),
    .vec_mosi (vec_mosi),
    .vec_miso (vec_miso)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  //////////////////////////////
  // helpers

  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #1;   // drive point
  endtask

  task automatic finish_run();
    errors = errors + i_dut.i_asserts.fail_cnt;   // assertion failures count too
    $display("run done, %0d error(s)", errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles == cycle_limit) begin
      $display("timeout, run still going after %0d cycles", cycle_limit);
      errors = errors + 1;
      finish_run();
    end
  end

  task automatic check_data(input string name, input spi_periph_pkg::reg_data_t got,
                            input spi_periph_pkg::reg_data_t exp);
    if (got !== exp) begin
      errors = errors + 1;
      $display("MISMATCH %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_vec(input string name, input logic [n_dev-1:0] got,
                           input logic [n_dev-1:0] exp);
    if (got !== exp) begin
      errors = errors + 1;
      $display("MISMATCH %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors = errors + 1;
      $display("MISMATCH %s got %h exp %h", name, got, exp);
    end
  endtask

  //////////////////////////////
  // register model

  // bits at or above n_dev do not exist in the mask registers
  function automatic spi_periph_pkg::reg_data_t dev_bits(input spi_periph_pkg::reg_data_t v);
    spi_periph_pkg::reg_data_t r;
    r = '0;
    for (int i = 0; i < n_dev; i++)
      r[i] = v[i];
    return r;
  endfunction

  function automatic void model_write(input spi_periph_pkg::reg_addr_t a,
                                      input spi_periph_pkg::reg_data_t d);
    if (a == spi_periph_pkg::addr_spi_mux || a == spi_periph_pkg::addr_cs_polarity)
      model[a] = dev_bits(d);
    else if (a == spi_periph_pkg::addr_scratch)
      model[a] = d;
    // id and unmapped keep their value
  endfunction

  function automatic spi_periph_pkg::reg_data_t expected_read(input spi_periph_pkg::reg_addr_t a);
    if (a == spi_periph_pkg::addr_id)
      return spi_periph_pkg::id_value;
    else if (a < 8)
      return model[a];   // unmapped entries never leave zero
    else
      return '0;
  endfunction

  //////////////////////////////
  // spi master, mode 0

  task automatic spi_frame(input logic wr, input spi_periph_pkg::reg_addr_t a,
                           input spi_periph_pkg::reg_data_t wdata, input int bits,
                           output spi_periph_pkg::reg_data_t rdata);
    logic [15:0] word;
    word  = {wr, a, wdata};
    rdata = '0;
    spi_cs = 1'b0;
    tick(half_per);
    for (int i = 0; i < bits; i++) begin
      spi_mosi = word[15-i];            // set up while clock is low
      tick(half_per);
      if (i >= 8)
        rdata = {rdata[6:0], spi_miso}; // sample at the rise
      spi_clk = 1'b1;
      tick(half_per);
      spi_clk = 1'b0;
    end
    tick(half_per);
    spi_cs   = 1'b1;                    // end or cut the frame
    spi_mosi = 1'b0;
    tick(4);
  endtask

  task automatic write_reg(input spi_periph_pkg::reg_addr_t a, input spi_periph_pkg::reg_data_t d);
    spi_periph_pkg::reg_data_t unused;
    spi_frame(1'b1, a, d, 16, unused);
    model_write(a, d);
  endtask

  task automatic read_check(input spi_periph_pkg::reg_addr_t a);
    spi_periph_pkg::reg_data_t got;
    spi_frame(1'b0, a, '0, 16, got);
    check_data($sformatf("rd_data[%0d]", a), got, expected_read(a));
  endtask

  //////////////////////////////
  // pass-through

  task automatic pass_step(input logic cs2);
    logic [n_dev-1:0] mask;
    logic [n_dev-1:0] pol;
    logic [n_dev-1:0] cs_exp;
    logic             active;
    mask     = model[spi_periph_pkg::addr_spi_mux][n_dev-1:0];
    pol      = model[spi_periph_pkg::addr_cs_polarity][n_dev-1:0];
    spi_cs2  = cs2;
    spi_clk  = $urandom % 2;
    spi_mosi = $urandom % 2;
    vec_miso = $urandom;
    for (int i = 0; i < n_dev; i++) begin
      active    = mask[i] && !cs2;
      cs_exp[i] = pol[i] ? active : !active;   // active high strobe vs normal cs
    end
    @(negedge clk);   // settled, mid cycle
    check_vec("vec_cs", vec_cs, cs_exp);
    check_vec("vec_clk", vec_clk, spi_clk ? mask : '0);
    check_vec("vec_mosi", vec_mosi, spi_mosi ? mask : '0);
    if (!cs2)
      check_bit("spi_miso", spi_miso, |(mask & vec_miso));
    else
      check_bit("spi_miso", spi_miso, 1'b0);   // hub idle, shifter cleared
    tick(1);
    spi_cs2  = 1'b1;
    spi_clk  = 1'b0;
    spi_mosi = 1'b0;
  endtask

  //////////////////////////////
  // main sequence

  initial begin
    errors   = 0;
    cycles   = 0;
    rst      = 1'b1;
    spi_clk  = 1'b0;
    spi_cs   = 1'b1;
    spi_cs2  = 1'b1;
    spi_mosi = 1'b0;
    vec_miso = '0;
    for (int i = 0; i < 8; i++)
      model[i] = '0;
    void'($urandom(11));
    tick(4);
    rst = 1'b0;
    tick(2);

    // reset values
    for (int a = 0; a < 4; a++)
      read_check(spi_periph_pkg::reg_addr_t'(a));
    pass_step(1'b1);

    // random register traffic
    for (int n = 0; n < 300; n++) begin
      addr = spi_periph_pkg::reg_addr_t'($urandom % 8);
      data = $urandom;
      if ($urandom % 2)
        write_reg(addr, data);
      else
        read_check(addr);
    end

    // routing and miso select
    for (int n = 0; n < 20; n++) begin
      write_reg(spi_periph_pkg::addr_spi_mux, $urandom);
      write_reg(spi_periph_pkg::addr_cs_polarity, $urandom);
      repeat (16)
        pass_step(($urandom % 4) == 0);   // mostly cs2 low
    end

    // cut write frames
    for (int n = 0; n < 30; n++) begin
      addr = spi_periph_pkg::reg_addr_t'($urandom % 3);
      data = $urandom;
      if (dev_bits(data) == expected_read(addr))
        data = ~data;                     // make a lost write visible
      cut = $urandom % 16;
      spi_frame(1'b1, addr, data, cut, dummy);
      read_check(addr);
    end

    finish_run();
  end

endmodule

// ==== spi_periph.f ====
hdl/spi_periph_pkg.sv
hdl/spi_shift.sv
hdl/spi_frame_ctrl.sv
hdl/spi_reg_bank.sv
hdl/mux_spi.sv
hdl/spi_periph_top.sv
sim/spi_periph_asserts.sv
sim/spi_periph_tb.sv
